// ==== design/neurram_pkg.sv ====
// shared widths, timing constants and enums for the matmul input controller
// imported by every RTL block and by the testbench

package neurram_pkg;

	// ----------------------------------------
	// field widths
	// ----------------------------------------
	localparam int CMD_DATA_W   = 8;
	localparam int NUM_BITS_W   = 4;   // 0 to 8 input bits
	localparam int PULSE_MULT_W = 5;
	localparam int T_SAMPLE_W   = 8;   // sample width in sys_clk cycles
	localparam int PULSE_CNT_W  = 13;  // holds 31 x 128

	// command queue, also the host's starting credit count
	localparam int CMD_DEPTH = 4;
	localparam int CMD_PTR_W = $clog2(CMD_DEPTH);

	// ----------------------------------------
	// switch timing
	// ----------------------------------------
	localparam int T_CDS = 4;  // fixed cds pulse width
	localparam int T_GAP = 2;  // min low time after any pulse

	// pulse kind on the sequencer to driver link
	localparam logic KIND_SAMPLE = 1'b0;
	localparam logic KIND_CDS    = 1'b1;

	// ----------------------------------------
	// opcodes and state encodings
	// ----------------------------------------
	typedef enum logic [1:0] {
		OP_SET_BITS  = 2'd0,  // data = number of input bits
		OP_SET_MULT  = 2'd1,  // data = pulse multiplier
		OP_SET_WIDTH = 2'd2,  // data = sample width
		OP_RUN       = 2'd3   // data[0] = cds per bit
	} cmd_op_t;

	typedef enum logic [2:0] {
		S_IDLE     = 3'd0,
		S_CDS      = 3'd1,
		S_BURST    = 3'd2,
		S_NEXT_BIT = 3'd3,
		S_DONE     = 3'd4
	} seq_state_t;

	typedef enum logic [1:0] {
		D_IDLE = 2'd0,
		D_HIGH = 2'd1,
		D_GAP  = 2'd2
	} drv_state_t;

endpackage

// ==== design/host_cmd_decoder.sv ====
// host command queue with credit return
// config commands at the head write their register and pop at once,
// a run command waits at the head until the sequencer acknowledges it

`timescale 1ns/1ns

module host_cmd_decoder import neurram_pkg::*; (
	input  logic                    sys_clk,
	input  logic                    arst_n_i,
	input  logic                    cmd_valid_i,
	input  cmd_op_t                 cmd_op_i,
	input  logic [CMD_DATA_W-1:0]   cmd_data_i,
	input  logic                    run_ack_i,
	output logic                    credit_o,
	output logic                    run_req_o,
	output logic                    run_cds_o,
	output logic [NUM_BITS_W-1:0]   num_bits_o,
	output logic [PULSE_MULT_W-1:0] pulse_mult_o,
	output logic [T_SAMPLE_W-1:0]   t_sample_o
);

	cmd_op_t               op_mem   [CMD_DEPTH];
	logic [CMD_DATA_W-1:0] data_mem [CMD_DEPTH];

	logic [CMD_PTR_W-1:0] wr_ptr;
	logic [CMD_PTR_W-1:0] rd_ptr;
	logic [CMD_PTR_W:0]   count;

	logic                  head_valid;
	cmd_op_t               head_op;
	logic [CMD_DATA_W-1:0] head_data;
	logic                  cfg_pop;
	logic                  pop;

	// ----------------------------------------
	// head decode
	// ----------------------------------------
	assign head_valid = (count != '0);
	assign head_op    = op_mem[rd_ptr];
	assign head_data  = data_mem[rd_ptr];

	assign cfg_pop   = head_valid && (head_op != OP_RUN);
	assign run_req_o = head_valid && (head_op == OP_RUN);
	assign run_cds_o = head_data[0];
	assign pop       = cfg_pop || (run_req_o && run_ack_i);

	// queue storage, host never overruns it
	always_ff @(posedge sys_clk) begin
		if (cmd_valid_i) begin
			op_mem[wr_ptr]   <= cmd_op_i;
			data_mem[wr_ptr] <= cmd_data_i;
		end
	end

	always_ff @(posedge sys_clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			count    <= '0;
			credit_o <= 1'b0;
		end else begin
			if (cmd_valid_i)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({cmd_valid_i, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			credit_o <= pop;  // one credit per popped entry
		end
	end

	// ----------------------------------------
	// configuration registers
	// ----------------------------------------
	always_ff @(posedge sys_clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			num_bits_o   <= NUM_BITS_W'(1);
			pulse_mult_o <= PULSE_MULT_W'(1);
			t_sample_o   <= T_SAMPLE_W'(1);
		end else if (cfg_pop) begin
			case (head_op)
				OP_SET_BITS:  num_bits_o   <= head_data[NUM_BITS_W-1:0];
				OP_SET_MULT:  pulse_mult_o <= head_data[PULSE_MULT_W-1:0];
				OP_SET_WIDTH: t_sample_o   <= head_data[T_SAMPLE_W-1:0];
				default: ;  // run is never a config pop
			endcase
		end
	end

endmodule

// ==== design/matmul_bit_sequencer.sv ====
// unsigned matmul input sequencer
// per input bit b: optional cds pulse, then pulse_mult << b sample pulses,
// handed to the switch driver one request at a time

`timescale 1ns/1ns

module matmul_bit_sequencer import neurram_pkg::*; (
	input  logic                    sys_clk,
	input  logic                    arst_n_i,
	input  logic                    run_req_i,
	input  logic                    run_cds_i,
	input  logic [NUM_BITS_W-1:0]   num_bits_i,
	input  logic [PULSE_MULT_W-1:0] pulse_mult_i,
	input  logic                    drv_idle_i,
	output logic                    run_ack_o,
	output logic                    pulse_req_o,
	output logic                    pulse_kind_o,
	output logic                    ext_inference_enable_o,
	output logic                    matmul_done_o
);

	seq_state_t state;

	// run configuration, captured on ack
	logic                    cds_q;
	logic [NUM_BITS_W-1:0]   nbits_q;
	logic [PULSE_MULT_W-1:0] mult_q;

	logic [NUM_BITS_W-1:0]  bit_idx;
	logic [NUM_BITS_W-1:0]  next_bit;
	logic [PULSE_CNT_W-1:0] pulse_cnt;  // sample pulses left in this burst
	logic [PULSE_CNT_W-1:0] mult_ext;
	logic                   empty_run;

	assign next_bit  = bit_idx + 1'b1;
	assign mult_ext  = PULSE_CNT_W'(mult_q);
	assign empty_run = (num_bits_i == '0) || (pulse_mult_i == '0);

	// ----------------------------------------
	// handshakes and status
	// ----------------------------------------
	assign run_ack_o    = (state == S_IDLE) && run_req_i;
	assign pulse_req_o  = drv_idle_i &&
		((state == S_CDS) || ((state == S_BURST) && (pulse_cnt != '0)));
	assign pulse_kind_o = (state == S_CDS) ? KIND_CDS : KIND_SAMPLE;

	assign ext_inference_enable_o = (state != S_IDLE);
	assign matmul_done_o          = (state == S_DONE);

	always_ff @(posedge sys_clk) begin
		if (run_ack_o) begin
			cds_q   <= run_cds_i;
			nbits_q <= num_bits_i;
			mult_q  <= pulse_mult_i;
		end
	end

	// ----------------------------------------
	// bit and pulse walk
	// ----------------------------------------
	always_ff @(posedge sys_clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state     <= S_IDLE;
			bit_idx   <= '0;
			pulse_cnt <= '0;
		end else begin
			case (state)
				S_IDLE: begin
					if (run_req_i) begin
						bit_idx   <= '0;
						pulse_cnt <= PULSE_CNT_W'(pulse_mult_i);  // bit 0 burst
						if (empty_run)
							state <= S_DONE;
						else if (run_cds_i)
							state <= S_CDS;
						else
							state <= S_BURST;
					end
				end
				S_CDS: begin
					if (drv_idle_i)
						state <= S_BURST;  // cds request goes out this cycle
				end
				S_BURST: begin
					if (drv_idle_i) begin
						if (pulse_cnt != '0)
							pulse_cnt <= pulse_cnt - 1'b1;
						else
							state <= S_NEXT_BIT;  // last pulse and gap finished
					end
				end
				S_NEXT_BIT: begin
					bit_idx <= next_bit;
					if (next_bit == nbits_q) begin
						state <= S_DONE;
					end else begin
						pulse_cnt <= mult_ext << next_bit;
						state     <= cds_q ? S_CDS : S_BURST;
					end
				end
				S_DONE:  state <= S_IDLE;
				default: state <= S_IDLE;
			endcase
		end
	end

endmodule

// ==== design/neuron_switch_driver.sv ====
// neuron sampling switch timing
// holds sw_in_sample for t_sample cycles or sw_cds for T_CDS cycles,
// then keeps both low for T_GAP cycles before accepting the next request

`timescale 1ns/1ns

module neuron_switch_driver import neurram_pkg::*; (
	input  logic                  sys_clk,
	input  logic                  arst_n_i,
	input  logic                  pulse_req_i,
	input  logic                  pulse_kind_i,
	input  logic [T_SAMPLE_W-1:0] t_sample_i,
	output logic                  drv_idle_o,
	output logic                  sw_in_sample_o,
	output logic                  sw_cds_o
);

	drv_state_t state;

	logic                  kind_q;    // kind of the pulse in flight
	logic [T_SAMPLE_W-1:0] width_cnt; // cycles left minus one
	logic [T_SAMPLE_W-1:0] high_len;

	// zero width runs as one cycle
	assign high_len = (pulse_kind_i == KIND_CDS) ? T_SAMPLE_W'(T_CDS - 1) :
		(t_sample_i == '0) ? '0 : t_sample_i - 1'b1;

	assign drv_idle_o     = (state == D_IDLE);
	assign sw_in_sample_o = (state == D_HIGH) && (kind_q == KIND_SAMPLE);
	assign sw_cds_o       = (state == D_HIGH) && (kind_q == KIND_CDS);

	always_ff @(posedge sys_clk) begin
		if (pulse_req_i && drv_idle_o)
			kind_q <= pulse_kind_i;
	end

	// ----------------------------------------
	// pulse timing
	// ----------------------------------------
	always_ff @(posedge sys_clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state     <= D_IDLE;
			width_cnt <= '0;
		end else begin
			case (state)
				D_IDLE: begin
					if (pulse_req_i) begin
						state     <= D_HIGH;  // switch rises next cycle
						width_cnt <= high_len;
					end
				end
				D_HIGH: begin
					if (width_cnt == '0) begin
						state     <= D_GAP;
						width_cnt <= T_SAMPLE_W'(T_GAP - 1);
					end else begin
						width_cnt <= width_cnt - 1'b1;
					end
				end
				D_GAP: begin
					if (width_cnt == '0)
						state <= D_IDLE;
					else
						width_cnt <= width_cnt - 1'b1;
				end
				default: state <= D_IDLE;
			endcase
		end
	end

endmodule

// ==== design/neurram_ctrl_top.sv ====
// matmul input controller top
// host command port in, neuron sampling switches and run status out

`timescale 1ns/1ns

module neurram_ctrl_top import neurram_pkg::*; (
	input  logic                  sys_clk,
	input  logic                  arst_n_i,
	input  logic                  cmd_valid_i,
	input  cmd_op_t               cmd_op_i,
	input  logic [CMD_DATA_W-1:0] cmd_data_i,
	output logic                  credit_o,
	output logic                  sw_in_sample_o,
	output logic                  sw_cds_o,
	output logic                  ext_inference_enable_o,
	output logic                  matmul_done_o
);

	// decoder to sequencer
	logic                    run_req;
	logic                    run_cds;
	logic                    run_ack;
	logic [NUM_BITS_W-1:0]   num_bits;
	logic [PULSE_MULT_W-1:0] pulse_mult;
	logic [T_SAMPLE_W-1:0]   t_sample;

	// sequencer to driver
	logic pulse_req;
	logic pulse_kind;
	logic drv_idle;

	host_cmd_decoder u_decoder (
		.sys_clk      (sys_clk),
		.arst_n_i     (arst_n_i),
		.cmd_valid_i  (cmd_valid_i),
		.cmd_op_i     (cmd_op_i),
		.cmd_data_i   (cmd_data_i),
		.run_ack_i    (run_ack),
		.credit_o     (credit_o),
		.run_req_o    (run_req),
		.run_cds_o    (run_cds),
		.num_bits_o   (num_bits),
		.pulse_mult_o (pulse_mult),
		.t_sample_o   (t_sample)
	);

	matmul_bit_sequencer u_sequencer (
		.sys_clk                (sys_clk),
		.arst_n_i               (arst_n_i),
		.run_req_i              (run_req),
		.run_cds_i              (run_cds),
		.num_bits_i             (num_bits),
		.pulse_mult_i           (pulse_mult),
		.drv_idle_i             (drv_idle),
		.run_ack_o              (run_ack),
		.pulse_req_o            (pulse_req),
		.pulse_kind_o           (pulse_kind),
		.ext_inference_enable_o (ext_inference_enable_o),
		.matmul_done_o          (matmul_done_o)
	);

	neuron_switch_driver u_driver (
		.sys_clk        (sys_clk),
		.arst_n_i       (arst_n_i),
		.pulse_req_i    (pulse_req),
		.pulse_kind_i   (pulse_kind),
		.t_sample_i     (t_sample),
		.drv_idle_o     (drv_idle),
		.sw_in_sample_o (sw_in_sample_o),
		.sw_cds_o       (sw_cds_o)
	);

endmodule

// ==== test/tb_neurram_ctrl.sv ====
// testbench for the matmul input controller
// sends config and run commands under credit flow control, predicts pulse
// counts and widths per run and checks the switch pins with assertions

`timescale 1ns/1ns

module tb_neurram_ctrl import neurram_pkg::*; ();

	localparam int MAX_BITS  = 4;  // random run bounds
	localparam int MAX_MULT  = 3;
	localparam int MAX_WIDTH = 3;
	localparam int N_RANDOM  = 10;
	localparam int NUM_RUNS  = N_RANDOM + 6;
	localparam int WORST_RUN = MAX_MULT * ((1 << MAX_BITS) - 1) * (MAX_WIDTH + T_GAP + 2)
		+ MAX_BITS * (T_CDS + T_GAP + 4);
	localparam int TIMEOUT_CYCLES = NUM_RUNS * (WORST_RUN + 20) + 100;

	logic                  sys_clk = 1'b0;
	logic                  arst_n_i;
	logic                  cmd_valid_i;
	cmd_op_t               cmd_op_i;
	logic [CMD_DATA_W-1:0] cmd_data_i;
	logic                  credit_o;
	logic                  sw_in_sample_o;
	logic                  sw_cds_o;
	logic                  ext_inference_enable_o;
	logic                  matmul_done_o;

	// host side model of the config registers
	int m_bits = 1;
	int m_mult = 1;
	int m_width = 1;
	int exp_samples[$];
	int exp_cds[$];
	int exp_width[$];
	int exp_mult[$];
	int exp_empty[$];

	int sent_cnt = 0;
	int credit_cnt = 0;
	int cycle = 0;
	int last_credit_cyc = 0;
	int sample_cnt = 0;
	int cds_cnt = 0;
	int samp_len = 0;
	int cds_len = 0;
	int low_len = T_GAP;
	logic prev_sample = 1'b0;
	logic prev_cds = 1'b0;
	logic prev_enable = 1'b0;
	logic prev_done = 1'b0;
	logic [31:0] rng = 32'd20522;

	neurram_ctrl_top dut (.*);

	always #2 sys_clk = ~sys_clk;

	task automatic fail_value(input string name, input int expected, input int actual);
		$display("[FAIL] t=%0t %s expected %0d got %0d", $time, name, expected, actual);
		$display("ERRORS FOUND");
		$fatal(1, "stopped on first check failure");
	endtask

	task automatic fail_text(input string msg);
		$display("error at t=%0t: %s", $time, msg);
		$display("ERRORS FOUND");
		$fatal(1, "stopped on first check failure");
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic int rand_below(input int bound);
		rng = xorshift32(rng);
		return int'(rng % 32'(bound));
	endfunction

	// ----------------------------------------
	// host side credits and expected results
	// ----------------------------------------
	task automatic send_cmd(input cmd_op_t op, input int data);
		int total;
		while (sent_cnt - credit_cnt >= CMD_DEPTH)
			@(negedge sys_clk);  // out of credits
		cmd_valid_i = 1'b1;
		cmd_op_i    = op;
		cmd_data_i  = CMD_DATA_W'(data);
		case (op)
			OP_SET_BITS:  m_bits = data;
			OP_SET_MULT:  m_mult = data;
			OP_SET_WIDTH: m_width = data;
			default: begin
				total = (m_bits == 0 || m_mult == 0) ? 0 : m_mult * ((1 << m_bits) - 1);
				exp_samples.push_back(total);
				exp_cds.push_back((total != 0 && data[0]) ? m_bits : 0);
				exp_width.push_back((m_width == 0) ? 1 : m_width);
				exp_mult.push_back(m_mult);
				exp_empty.push_back(total == 0);
			end
		endcase
		@(negedge sys_clk);
		cmd_valid_i = 1'b0;
	endtask

	task automatic do_run(input int bits, input int mult, input int width, input int cds);
		send_cmd(OP_SET_BITS, bits);
		send_cmd(OP_SET_MULT, mult);
		send_cmd(OP_SET_WIDTH, width);
		send_cmd(OP_RUN, cds);
	endtask

	task automatic wait_runs_done();
		while (exp_samples.size() != 0)
			@(negedge sys_clk);
	endtask

	// ----------------------------------------
	// concurrent checks
	// ----------------------------------------
	assert property (@(posedge sys_clk) disable iff (!arst_n_i) !(sw_cds_o && sw_in_sample_o))
		else fail_text("sw_cds_o and sw_in_sample_o were high together");
	assert property (@(posedge sys_clk) disable iff (!arst_n_i)
		(sw_in_sample_o || sw_cds_o) |-> ext_inference_enable_o)
		else fail_value("ext_inference_enable_o", 1, int'(ext_inference_enable_o));

	// pin monitor sampling at the rising edge
	always @(posedge sys_clk) begin
		cycle++;
		if (cycle >= TIMEOUT_CYCLES)
			fail_text("simulation hung, runs did not finish before the cycle limit");
		if (arst_n_i) begin
			sent_cnt += int'(cmd_valid_i);
			if (credit_o) begin
				credit_cnt++;
				last_credit_cyc = cycle;
			end
			assert (credit_cnt <= sent_cnt) else fail_value("credit_o total", sent_cnt, credit_cnt);

			if ((sw_in_sample_o && !prev_sample) || (sw_cds_o && !prev_cds)) begin
				if (exp_samples.size() == 0)
					fail_text("switch pulse seen with no run pending");
				assert (low_len >= T_GAP) else fail_value("switch gap", T_GAP, low_len);
			end
			if (sw_in_sample_o && !prev_sample) begin
				if (exp_cds[0] != 0) begin  // burst must follow its cds pulse
					assert (sample_cnt < exp_mult[0] * ((1 << cds_cnt) - 1))
						else fail_text("sample pulse issued before its bit's cds pulse");
				end
				sample_cnt++;
			end
			if (sw_cds_o && !prev_cds) begin
				assert (sample_cnt == exp_mult[0] * ((1 << cds_cnt) - 1))
					else fail_value("sw_in_sample_o count at cds", exp_mult[0] * ((1 << cds_cnt) - 1),
						sample_cnt);
				cds_cnt++;
			end

			if (sw_in_sample_o) begin
				samp_len++;
			end else if (prev_sample) begin
				assert (samp_len == exp_width[0])
					else fail_value("sw_in_sample_o width", exp_width[0], samp_len);
				samp_len = 0;
			end
			if (sw_cds_o) begin
				cds_len++;
			end else if (prev_cds) begin
				assert (cds_len == T_CDS) else fail_value("sw_cds_o width", T_CDS, cds_len);
				cds_len = 0;
			end
			if (sw_in_sample_o || sw_cds_o)
				low_len = 0;
			else
				low_len++;

			// run completion in issue order
			if (matmul_done_o) begin
				if (exp_samples.size() == 0)
					fail_text("matmul_done_o with no run pending");
				assert (ext_inference_enable_o) else fail_value("ext_inference_enable_o", 1, 0);
				assert (sample_cnt == exp_samples[0])
					else fail_value("sw_in_sample_o pulses", exp_samples[0], sample_cnt);
				assert (cds_cnt == exp_cds[0])
					else fail_value("sw_cds_o pulses", exp_cds[0], cds_cnt);
				if (exp_empty[0] != 0) begin
					assert (cycle - last_credit_cyc <= 3)
						else fail_value("matmul_done_o delay", 3, cycle - last_credit_cyc);
				end
				void'(exp_samples.pop_front());
				void'(exp_cds.pop_front());
				void'(exp_width.pop_front());
				void'(exp_mult.pop_front());
				void'(exp_empty.pop_front());
				sample_cnt = 0;
				cds_cnt    = 0;
			end
			if (prev_enable && !ext_inference_enable_o) begin
				assert (prev_done) else fail_text("ext_inference_enable_o fell without matmul_done_o");
			end
			prev_sample = sw_in_sample_o;
			prev_cds    = sw_cds_o;
			prev_enable = ext_inference_enable_o;
			prev_done   = matmul_done_o;
		end
	end

	// ----------------------------------------
	// test sequence
	// ----------------------------------------
	initial begin
		arst_n_i    = 1'b0;
		cmd_valid_i = 1'b0;
		cmd_op_i    = OP_SET_BITS;
		cmd_data_i  = '0;
		repeat (5) @(negedge sys_clk);
		arst_n_i = 1'b1;
		repeat (3) @(negedge sys_clk);
		assert (!credit_o) else fail_value("credit_o", 0, 1);
		assert (!sw_in_sample_o) else fail_value("sw_in_sample_o", 0, 1);
		assert (!sw_cds_o) else fail_value("sw_cds_o", 0, 1);
		assert (!ext_inference_enable_o) else fail_value("ext_inference_enable_o", 0, 1);
		assert (!matmul_done_o) else fail_value("matmul_done_o", 0, 1);

		send_cmd(OP_RUN, 0);  // reset config gives one pulse
		wait_runs_done();
		for (int i = 0; i < N_RANDOM; i++) begin
			do_run(rand_below(MAX_BITS) + 1, rand_below(MAX_MULT) + 1,
				rand_below(MAX_WIDTH + 1), rand_below(2));
			wait_runs_done();
		end

		// config queued behind a run belongs to the next run
		do_run(3, 2, 2, 1);
		send_cmd(OP_SET_BITS, 2);
		send_cmd(OP_SET_MULT, 1);
		send_cmd(OP_RUN, 0);
		// fill the queue behind the waiting run so the host runs out of credits
		send_cmd(OP_SET_BITS, 1);
		send_cmd(OP_SET_MULT, 3);
		send_cmd(OP_SET_BITS, 2);
		send_cmd(OP_RUN, 1);
		wait_runs_done();

		do_run(0, 2, 1, 1);  // empty runs
		wait_runs_done();
		do_run(2, 0, 1, 0);
		wait_runs_done();

		repeat (4) @(negedge sys_clk);
		if (credit_cnt == sent_cnt) begin
			$display("NO ERRORS");
			$finish;
		end else begin
			fail_value("credit_o total", sent_cnt, credit_cnt);
		end
	end

endmodule

// ==== neurram_ctrl.f ====
design/neurram_pkg.sv
design/host_cmd_decoder.sv
design/matmul_bit_sequencer.sv
design/neuron_switch_driver.sv
design/neurram_ctrl_top.sv
test/tb_neurram_ctrl.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_neurram_ctrl
LOG       ?= sim.log

FLIST := neurram_ctrl.f
SRCS  := $(shell grep -v '^+' $(FLIST))
BIN   := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) --binary --timing --assert -Wno-fatal --top-module $(TOP) -f $(FLIST)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then echo "simulation failed"; exit 1; \
	elif ! grep -q "NO ERRORS" $(LOG); then echo "simulation incomplete"; exit 1; \
	else echo "simulation passed"; fi

clean:
	rm -rf obj_dir $(LOG)
